// File: sim.f
rtl/lsu_pkg.sv
rtl/lsu_addr_decode.sv
rtl/lsu_dccm_ctl.sv
rtl/lsu_load_align.sv
rtl/lsu_top.sv
tb/lsu_mem_model.sv
tb/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - files:
      - rtl/lsu_pkg.sv
      - rtl/lsu_addr_decode.sv
      - rtl/lsu_dccm_ctl.sv
      - rtl/lsu_load_align.sv
      - rtl/lsu_top.sv
  - target: simulation
    files:
      - tb/lsu_mem_model.sv
      - tb/lsu_tb.sv

// File: tb/lsu_tb.sv
// LSU testbench
module lsu_tb
   import lsu_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   typedef struct packed {
      logic        store;   // Else load
      lsu_size_e   size;
      logic        unsign;
      logic        rnd;     // Store data from the xorshift stream
      lsu_addr_t   base;
      lsu_offset_t offset;
      lsu_word_t   data;
   } op_t;

   typedef struct packed {
      logic           valid;      // Op in m this cycle
      logic           res_valid;
      lsu_word_t      result;
      lsu_error_pkt_t err;
      logic           dccm_we;
      logic           pic_we;
      lsu_addr_t      addr;
      lsu_word_t      wr_data;    // Store data on its lanes
      lsu_byteen_t    byteen;     // Lanes the store touches
   } expect_t;

   logic           clk = 1'b0;
   logic           reset;
   lsu_pkt_t       lsu_p;
   lsu_word_t      exu_lsu_rs1_d;
   lsu_word_t      exu_lsu_rs2_d;
   lsu_offset_t    dec_lsu_offset_d;
   logic           dccm_rden;
   dccm_addr_t     dccm_rd_addr;
   logic           dccm_wren;
   dccm_addr_t     dccm_wr_addr;
   lsu_word_t      dccm_wr_data;
   lsu_byteen_t    dccm_wr_byteen;
   lsu_word_t      dccm_rd_data;
   logic           picm_rden;
   lsu_addr_t      picm_rdaddr;
   logic           picm_wren;
   lsu_addr_t      picm_wraddr;
   lsu_word_t      picm_wr_data;
   lsu_word_t      picm_rd_data;
   logic           lsu_result_valid_m;
   lsu_word_t      lsu_result_m;
   lsu_error_pkt_t lsu_error_pkt_m;
   logic           lsu_idle_any;

   op_t       ops [$];           // Stimulus table
   expect_t   pend;              // Expected m response of the last op
   lsu_word_t dccm_shadow [int]; // Written words only, keyed by word index
   lsu_word_t pic_shadow [int];
   lsu_word_t rng = 32'hec37;
   int        errors = 0;

   lsu_top dut0 (.*);
   lsu_mem_model mem0 (.*);

   always #50 clk = ~clk;  // 100 ns period

   // *******************************************************************
   // Compare tasks
   // *******************************************************************
   task automatic check_word(string name, lsu_word_t got, lsu_word_t exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_error(lsu_error_pkt_t got, lsu_error_pkt_t exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] lsu_error_pkt_m: got %h expected %h", got, exp);
      end
   endtask

   function automatic lsu_word_t next_random();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // Shadow lookup, falls back to the model's power-up pattern
   function automatic lsu_word_t shadow_read(logic pic, lsu_addr_t addr);
      int        idx;
      lsu_word_t fill;
      idx = pic ? int'((addr - PIC_BASE) >> 2) : int'((addr - DCCM_BASE) >> 2);
      if (pic) begin
         fill = {3'b011, idx[12:0], 3'b100, ~idx[12:0]};
         return pic_shadow.exists(idx) ? pic_shadow[idx] : fill;
      end
      fill = {2'b10, idx[13:0], 2'b01, ~idx[13:0]};
      return dccm_shadow.exists(idx) ? dccm_shadow[idx] : fill;
   endfunction

   task automatic shadow_write(logic pic, lsu_addr_t addr, lsu_word_t lanes, lsu_byteen_t be);
      lsu_word_t w;
      int        idx;
      w = shadow_read(pic, addr);
      for (int i = 0; i < 4; i++) begin
         if (be[i])
            w[8*i +: 8] = lanes[8*i +: 8];  // Only enabled bytes change
      end
      idx = pic ? int'((addr - PIC_BASE) >> 2) : int'((addr - DCCM_BASE) >> 2);
      if (pic)
         pic_shadow[idx] = w;
      else
         dccm_shadow[idx] = w;
   endtask

   // Lane pick and extension of a load
   function automatic lsu_word_t load_value(lsu_word_t w, lsu_addr_t addr, lsu_size_e size,
                                            logic unsign);
      lsu_word_t s;
      s = w >> (8 * addr[1:0]);
      case (size)
         SZ_BYTE: return unsign ? {24'b0, s[7:0]} : {{24{s[7]}}, s[7:0]};
         SZ_HALF: return unsign ? {16'b0, s[15:0]} : {{16{s[15]}}, s[15:0]};
         default: return s;
      endcase
   endfunction

   function automatic op_t make_op(logic st, lsu_size_e sz, logic us, logic rnd,
                                   lsu_addr_t base, lsu_offset_t off, lsu_word_t data);
      op_t op;
      op.store  = st;
      op.size   = sz;
      op.unsign = us;
      op.rnd    = rnd;
      op.base   = base;
      op.offset = off;
      op.data   = data;
      return op;
   endfunction

   // *******************************************************************
   // Stimulus table: store, size, unsign, random, base, offset, data
   // *******************************************************************
   task automatic build_table();
      ops.push_back(make_op(1, SZ_WORD, 0, 0, DCCM_BASE + 'h100, 12'h000, 32'h1122_3344));
      ops.push_back(make_op(1, SZ_WORD, 0, 1, DCCM_BASE + 'h120, -12'sd4, 32'h0));
      ops.push_back(make_op(0, SZ_WORD, 0, 0, DCCM_BASE + 'h200, -12'sd256, 32'h0));
      ops.push_back(make_op(0, SZ_WORD, 0, 0, DCCM_BASE + 'h11c, 12'h000, 32'h0));
      ops.push_back(make_op(1, SZ_BYTE, 0, 0, DCCM_BASE + 'h100, 12'h001, 32'h0000_00a5));
      ops.push_back(make_op(1, SZ_HALF, 0, 0, DCCM_BASE + 'h100, 12'h002, 32'h0000_8001));
      ops.push_back(make_op(0, SZ_WORD, 0, 0, DCCM_BASE + 'h100, 12'h000, 32'h0));
      ops.push_back(make_op(0, SZ_BYTE, 0, 0, DCCM_BASE + 'h101, 12'h000, 32'h0));
      ops.push_back(make_op(0, SZ_BYTE, 1, 0, DCCM_BASE + 'h101, 12'h000, 32'h0));
      ops.push_back(make_op(0, SZ_HALF, 0, 0, DCCM_BASE + 'h102, 12'h000, 32'h0));
      ops.push_back(make_op(0, SZ_HALF, 1, 0, DCCM_BASE + 'h102, 12'h000, 32'h0));
      ops.push_back(make_op(1, SZ_WORD, 0, 0, DCCM_BASE + 'h140, 12'h000, 32'hcafe_f00d));
      ops.push_back(make_op(1, SZ_BYTE, 0, 0, DCCM_BASE + 'h143, 12'h000, 32'h0000_0012));
      ops.push_back(make_op(0, SZ_WORD, 0, 0, DCCM_BASE + 'h140, 12'h000, 32'h0));  // Forward
      ops.push_back(make_op(1, SZ_HALF, 0, 1, DCCM_BASE + 'h146, 12'h000, 32'h0));
      ops.push_back(make_op(0, SZ_HALF, 1, 0, DCCM_BASE + 'h146, 12'h000, 32'h0));  // Forward
      ops.push_back(make_op(1, SZ_HALF, 0, 0, DCCM_BASE + 'h141, 12'h000, 32'h0000_ffff));
      ops.push_back(make_op(1, SZ_WORD, 0, 0, DCCM_BASE + 'h142, 12'h000, 32'hdead_beef));
      ops.push_back(make_op(0, SZ_WORD, 0, 0, DCCM_BASE + 'h101, 12'h000, 32'h0));
      ops.push_back(make_op(1, SZ_WORD, 0, 0, 32'h8000_0000, 12'h000, 32'h5555_aaaa));
      ops.push_back(make_op(0, SZ_BYTE, 0, 0, 32'h0000_1000, 12'h000, 32'h0));
      ops.push_back(make_op(1, SZ_WORD, 0, 0, PIC_BASE + 'h10, 12'h000, 32'h0000_00ab));
      ops.push_back(make_op(1, SZ_BYTE, 0, 0, PIC_BASE + 'h10, 12'h001, 32'h0000_0077));
      ops.push_back(make_op(0, SZ_HALF, 0, 0, PIC_BASE + 'h10, 12'h000, 32'h0));
      ops.push_back(make_op(0, SZ_WORD, 0, 0, PIC_BASE + 'h10, 12'h000, 32'h0));
      ops.push_back(make_op(0, SZ_WORD, 0, 0, DCCM_BASE + 'h140, 12'h000, 32'h0));
      ops.push_back(make_op(0, SZ_WORD, 0, 0, DCCM_BASE + 'h300, 12'h000, 32'h0));  // Unwritten
      ops.push_back(make_op(0, SZ_WORD, 0, 0, DCCM_BASE + 'h7f0, -12'sd2048, 32'h0));  // Below
      ops.push_back(make_op(0, SZ_WORD, 0, 0, DCCM_BASE + 'hfffc, 12'h000, 32'h0));  // Last word
   endtask

   // Drive one op in d, check its read port, work out its m response
   task automatic apply_op(op_t op, output expect_t e);
      lsu_addr_t   addr;
      lsu_word_t   data;
      lsu_byteen_t be;
      logic        in_dccm;
      logic        in_pic;
      logic        mis;
      logic        fault;
      logic        legal;
      logic        rd;
      data    = op.rnd ? next_random() : op.data;
      addr    = op.base + {{20{op.offset[11]}}, op.offset};
      in_dccm = (addr >= DCCM_BASE) && (addr < DCCM_BASE + DCCM_SIZE);
      in_pic  = (addr >= PIC_BASE) && (addr < PIC_BASE + PIC_SIZE);
      mis     = (op.size == SZ_HALF && addr[0]) || (op.size == SZ_WORD && addr[1:0] != 2'b00);
      fault   = !mis && (!(in_dccm || in_pic) || (in_pic && op.size != SZ_WORD));
      legal   = !mis && !fault;
      rd      = legal && !op.store;
      be      = (op.size == SZ_BYTE) ? 4'b0001 : (op.size == SZ_HALF) ? 4'b0011 : 4'b1111;
      be      = be << addr[1:0];
      lsu_p.valid      = 1'b1;
      lsu_p.load       = !op.store;
      lsu_p.store      = op.store;
      lsu_p.size       = op.size;
      lsu_p.unsign     = op.unsign;
      exu_lsu_rs1_d    = op.base;
      exu_lsu_rs2_d    = data;
      dec_lsu_offset_d = op.offset;
      #1;
      check_bit("dccm_rden", dccm_rden, rd && in_dccm);
      check_bit("picm_rden", picm_rden, rd && in_pic);
      if (rd && in_dccm)
         check_word("dccm_rd_addr", {18'b0, dccm_rd_addr}, {18'b0, addr[DCCM_BITS-1:2]});
      if (rd && in_pic)
         check_word("picm_rdaddr", picm_rdaddr, addr);
      e.valid     = 1'b1;
      e.res_valid = rd;
      e.result    = rd ? load_value(shadow_read(in_pic, addr), addr, op.size, op.unsign) : '0;
      e.err       = {!legal, op.store, mis, fault, addr};
      e.dccm_we   = legal && op.store && in_dccm;
      e.pic_we    = legal && op.store && in_pic;
      e.addr      = addr;
      e.wr_data   = data << (8 * addr[1:0]);
      e.byteen    = be;
      if (legal && op.store)
         shadow_write(in_pic, addr, e.wr_data, be);  // Later loads see this store
   endtask

   // Response of the op now in m
   task automatic check_m(expect_t e);
      check_bit("lsu_idle_any", lsu_idle_any, !e.valid);
      check_bit("lsu_result_valid_m", lsu_result_valid_m, e.res_valid);
      check_bit("dccm_wren", dccm_wren, e.dccm_we);
      check_bit("picm_wren", picm_wren, e.pic_we);
      if (!e.valid)
         check_bit("exc_valid", lsu_error_pkt_m.exc_valid, 1'b0);
      else
         check_error(lsu_error_pkt_m, e.err);
      if (e.res_valid)
         check_word("lsu_result_m", lsu_result_m, e.result);
      if (e.dccm_we) begin
         check_word("dccm_wr_addr", {18'b0, dccm_wr_addr}, {18'b0, e.addr[DCCM_BITS-1:2]});
         check_word("dccm_wr_data", dccm_wr_data, e.wr_data);
         check_word("dccm_wr_byteen", {28'b0, dccm_wr_byteen}, {28'b0, e.byteen});
      end
      if (e.pic_we) begin
         check_word("picm_wraddr", picm_wraddr, e.addr);
         check_word("picm_wr_data", picm_wr_data, e.wr_data);
      end
   endtask

   // *******************************************************************
   // Main sequence and watchdog
   // *******************************************************************
   initial begin
      reset            = 1'b1;
      lsu_p            = '0;
      exu_lsu_rs1_d    = '0;
      exu_lsu_rs2_d    = '0;
      dec_lsu_offset_d = '0;
      pend             = '0;
      build_table();
      repeat (3) @(posedge clk);
      #5;
      reset = 1'b0;
      check_m(pend);  // Idle state straight out of reset
      check_bit("dccm_rden", dccm_rden, 1'b0);
      check_bit("picm_rden", picm_rden, 1'b0);
      for (int i = 0; i < ops.size(); i++) begin
         @(posedge clk);
         #5;
         check_m(pend);  // Previous op, m outputs settled
         apply_op(ops[i], pend);
      end
      @(posedge clk);
      #5;
      check_m(pend);
      lsu_p = '0;
      $display("Run complete: %0d errors over %0d operations", errors, ops.size());
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      #1;
      #((ops.size() + 20) * 100);  // One op per 100 ns cycle plus margin
      $display("Timeout: the run did not finish within %0d cycles", ops.size() + 20);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// File: tb/lsu_mem_model.sv
// DCCM and PIC memory models
module lsu_mem_model
   import lsu_pkg::*;
(
   input  logic        clk,
   input  logic        dccm_rden,
   input  dccm_addr_t  dccm_rd_addr,
   input  logic        dccm_wren,
   input  dccm_addr_t  dccm_wr_addr,
   input  lsu_word_t   dccm_wr_data,
   input  lsu_byteen_t dccm_wr_byteen,
   output lsu_word_t   dccm_rd_data,     // Valid one cycle after dccm_rden
   input  logic        picm_rden,
   input  lsu_addr_t   picm_rdaddr,
   input  logic        picm_wren,
   input  lsu_addr_t   picm_wraddr,
   input  lsu_word_t   picm_wr_data,
   output lsu_word_t   picm_rd_data      // Valid one cycle after picm_rden
);
   timeunit 1ns;
   timeprecision 100ps;

   lsu_word_t dccm_mem [2**DCCM_WORD_BITS];
   lsu_word_t pic_mem  [int'(PIC_SIZE >> 2)];

   // Power-up contents, every bit of the word index shows up in the word
   initial begin
      for (int i = 0; i < 2**DCCM_WORD_BITS; i++) begin
         dccm_mem[i] = {2'b10, i[13:0], 2'b01, ~i[13:0]};
      end
      for (int j = 0; j < int'(PIC_SIZE >> 2); j++) begin
         pic_mem[j] = {3'b011, j[12:0], 3'b100, ~j[12:0]};
      end
   end

   // *******************************************************************
   // Read and write ports, read data registered
   // *******************************************************************
   always @(posedge clk) begin
      if (dccm_rden)
         dccm_rd_data <= dccm_mem[dccm_rd_addr];
      if (picm_rden)
         picm_rd_data <= pic_mem[(picm_rdaddr - PIC_BASE) >> 2];
      for (int b = 0; b < 4; b++) begin
         if (dccm_wren && dccm_wr_byteen[b])
            dccm_mem[dccm_wr_addr][8*b +: 8] <= dccm_wr_data[8*b +: 8];  // Per lane
      end
      if (picm_wren)
         pic_mem[(picm_wraddr - PIC_BASE) >> 2] <= picm_wr_data;  // Words only
   end

endmodule

// File: rtl/lsu_top.sv
// Load store unit top
module lsu_top
   import lsu_pkg::*;
(
   input  logic           clk,
   input  logic           reset,

   // Request in d
   input  lsu_pkt_t       lsu_p,
   input  lsu_word_t      exu_lsu_rs1_d,     // Base
   input  lsu_word_t      exu_lsu_rs2_d,     // Store data
   input  lsu_offset_t    dec_lsu_offset_d,

   // DCCM ports
   output logic           dccm_rden,
   output dccm_addr_t     dccm_rd_addr,
   output logic           dccm_wren,
   output dccm_addr_t     dccm_wr_addr,
   output lsu_word_t      dccm_wr_data,
   output lsu_byteen_t    dccm_wr_byteen,
   input  lsu_word_t      dccm_rd_data,

   // PIC ports
   output logic           picm_rden,
   output lsu_addr_t      picm_rdaddr,
   output logic           picm_wren,
   output lsu_addr_t      picm_wraddr,
   output lsu_word_t      picm_wr_data,
   input  lsu_word_t      picm_rd_data,

   // Results in m
   output logic           lsu_result_valid_m,
   output lsu_word_t      lsu_result_m,
   output lsu_error_pkt_t lsu_error_pkt_m,
   output logic           lsu_idle_any
);

   lsu_stage_t stage_d;      // Decode to execute
   lsu_stage_t stage_m;      // Registered bundle
   lsu_word_t  load_word_m;  // Merged read word

   // *******************************************************************
   // Stages
   // *******************************************************************
   lsu_addr_decode addr_decode (
      .lsu_p, .exu_lsu_rs1_d, .exu_lsu_rs2_d, .dec_lsu_offset_d,
      .stage_d,
      .dccm_rden, .dccm_rd_addr, .picm_rden, .picm_rdaddr
   );

   lsu_dccm_ctl dccm_ctl (
      .clk, .reset, .stage_d,
      .dccm_rd_data, .picm_rd_data,
      .stage_m, .load_word_m,
      .dccm_wren, .dccm_wr_addr, .dccm_wr_data, .dccm_wr_byteen,
      .picm_wren, .picm_wraddr, .picm_wr_data
   );

   lsu_load_align load_align (
      .stage_m, .load_word_m,
      .lsu_result_valid_m, .lsu_result_m, .lsu_error_pkt_m, .lsu_idle_any
   );

endmodule

// File: rtl/lsu_load_align.sv
// LSU load result and exceptions
module lsu_load_align
   import lsu_pkg::*;
(
   input  lsu_stage_t     stage_m,             // Access now in m
   input  lsu_word_t      load_word_m,         // Word after forwarding merge
   output logic           lsu_result_valid_m,
   output lsu_word_t      lsu_result_m,
   output lsu_error_pkt_t lsu_error_pkt_m,
   output logic           lsu_idle_any         // Nothing in m
);

   lsu_word_t shifted;
   logic      sign_bit;
   logic      legal_m;

   // *******************************************************************
   // Data extraction
   // *******************************************************************
   assign shifted = load_word_m >> {stage_m.addr[1:0], 3'b000};  // Target lane to bit 0

   always_comb begin
      sign_bit = 1'b0;
      unique case (stage_m.pkt.size)
         SZ_BYTE: begin
            sign_bit     = ~stage_m.pkt.unsign & shifted[7];
            lsu_result_m = {{24{sign_bit}}, shifted[7:0]};
         end
         SZ_HALF: begin
            sign_bit     = ~stage_m.pkt.unsign & shifted[15];
            lsu_result_m = {{16{sign_bit}}, shifted[15:0]};
         end
         default: lsu_result_m = shifted;  // Word, aligned
      endcase
   end

   assign legal_m            = stage_m.pkt.valid & ~stage_m.misaligned & ~stage_m.fault;
   assign lsu_result_valid_m = legal_m & stage_m.pkt.load;

   // *******************************************************************
   // Exception packet
   // *******************************************************************
   assign lsu_error_pkt_m.exc_valid    = stage_m.pkt.valid & (stage_m.misaligned | stage_m.fault);
   assign lsu_error_pkt_m.is_store     = stage_m.pkt.store;
   assign lsu_error_pkt_m.misaligned   = stage_m.misaligned;
   assign lsu_error_pkt_m.access_fault = stage_m.fault;
   assign lsu_error_pkt_m.addr         = stage_m.addr;  // Faulting address

   assign lsu_idle_any = ~stage_m.pkt.valid;

   // Decode never flags a legal access
   always_comb begin
      assert final (!(lsu_result_valid_m && lsu_error_pkt_m.exc_valid))
         else $error("load result and exception valid together");
   end

endmodule

// File: rtl/lsu_dccm_ctl.sv
// LSU memory stage control
module lsu_dccm_ctl
   import lsu_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  lsu_stage_t  stage_d,         // From decode
   input  lsu_word_t   dccm_rd_data,    // One cycle after dccm_rden
   input  lsu_word_t   picm_rd_data,    // One cycle after picm_rden
   output lsu_stage_t  stage_m,
   output lsu_word_t   load_word_m,     // Selected and forwarded read word
   output logic        dccm_wren,
   output dccm_addr_t  dccm_wr_addr,
   output lsu_word_t   dccm_wr_data,
   output lsu_byteen_t dccm_wr_byteen,
   output logic        picm_wren,
   output lsu_addr_t   picm_wraddr,
   output lsu_word_t   picm_wr_data
);

   logic        legal_m;
   logic        fwd_hit_d;     // Store in m, load in d, same DCCM word
   logic        fwd_hit_m;
   lsu_word_t   fwd_data_m;    // Store lanes seen by the load now in m
   lsu_byteen_t fwd_byteen_m;
   lsu_byteen_t size_mask;
   lsu_word_t   store_lanes;
   lsu_word_t   rd_word;

   // d to m register, control fields cleared on reset
   always_ff @(posedge clk) begin
      stage_m <= stage_d;
      if (reset) begin
         stage_m.pkt        <= '0;
         stage_m.region     <= '0;
         stage_m.misaligned <= 1'b0;
         stage_m.fault      <= 1'b0;
      end
   end

   // *******************************************************************
   // Store path
   // *******************************************************************
   always_comb begin
      unique case (stage_m.pkt.size)
         SZ_BYTE: size_mask = 4'b0001;
         SZ_HALF: size_mask = 4'b0011;
         default: size_mask = 4'b1111;
      endcase
   end

   assign store_lanes = stage_m.store_data << {stage_m.addr[1:0], 3'b000};  // Data to its lanes
   assign legal_m     = stage_m.pkt.valid & ~stage_m.misaligned & ~stage_m.fault;

   assign dccm_wren      = legal_m & stage_m.pkt.store & stage_m.region.in_dccm;
   assign dccm_wr_addr   = stage_m.addr[DCCM_BITS-1:2];
   assign dccm_wr_data   = store_lanes;
   assign dccm_wr_byteen = size_mask << stage_m.addr[1:0];
   assign picm_wren      = legal_m & stage_m.pkt.store & stage_m.region.in_pic;
   assign picm_wraddr    = stage_m.addr;
   assign picm_wr_data   = store_lanes;  // Word only, no shift in effect

   // *******************************************************************
   // Store to load forwarding
   // *******************************************************************
   assign fwd_hit_d = dccm_wren & stage_d.pkt.valid & stage_d.pkt.load &
                      ~stage_d.misaligned & ~stage_d.fault & stage_d.region.in_dccm &
                      (stage_d.addr[DCCM_BITS-1:2] == stage_m.addr[DCCM_BITS-1:2]);

   always_ff @(posedge clk) begin
      if (reset) begin
         fwd_hit_m <= 1'b0;
      end else begin
         fwd_hit_m <= fwd_hit_d;
      end
   end

   always_ff @(posedge clk) begin
      fwd_data_m   <= store_lanes;
      fwd_byteen_m <= dccm_wr_byteen;
   end

   assign rd_word = stage_m.region.in_pic ? picm_rd_data : dccm_rd_data;  // Read source

   // Store bytes replace stale read bytes
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         load_word_m[8*i +: 8] = (fwd_hit_m & fwd_byteen_m[i]) ? fwd_data_m[8*i +: 8]
                                                               : rd_word[8*i +: 8];
      end
   end

   // Illegal access in d never writes in m
   assert property (@(posedge clk) disable iff (reset)
      (stage_d.pkt.valid && (stage_d.misaligned || stage_d.fault)) |=>
         !(dccm_wren || picm_wren))
      else $error("write strobe on a misaligned or faulting access");

   assert property (@(posedge clk) disable iff (reset) $onehot0({dccm_wren, picm_wren}))
      else $error("dccm_wren and picm_wren both high");

endmodule

// File: rtl/lsu_addr_decode.sv
// LSU decode stage
module lsu_addr_decode
   import lsu_pkg::*;
(
   input  lsu_pkt_t    lsu_p,             // Control packet from decode
   input  lsu_word_t   exu_lsu_rs1_d,     // Base register
   input  lsu_word_t   exu_lsu_rs2_d,     // Store data
   input  lsu_offset_t dec_lsu_offset_d,  // Signed immediate
   output lsu_stage_t  stage_d,           // Bundle for the m stage
   output logic        dccm_rden,
   output dccm_addr_t  dccm_rd_addr,
   output logic        picm_rden,
   output lsu_addr_t   picm_rdaddr
);

   lsu_addr_t   offset_ext;
   lsu_addr_t   lsu_addr_d;
   lsu_region_t region_d;
   logic        access_d;
   logic        misaligned_d;
   logic        fault_d;
   logic        legal_load_d;

   // *******************************************************************
   // Address generation
   // *******************************************************************
   assign offset_ext = {{20{dec_lsu_offset_d[11]}}, dec_lsu_offset_d};  // Sign extend imm
   assign lsu_addr_d = exu_lsu_rs1_d + offset_ext;

   // Window compare, unsigned difference wraps for addresses below base
   assign region_d.in_dccm  = (lsu_addr_d - DCCM_BASE) < DCCM_SIZE;
   assign region_d.in_pic   = (lsu_addr_d - PIC_BASE) < PIC_SIZE;
   assign region_d.external = ~region_d.in_dccm & ~region_d.in_pic;

   assign access_d = lsu_p.valid & (lsu_p.load | lsu_p.store);

   // Natural alignment per size
   always_comb begin
      unique case (lsu_p.size)
         SZ_HALF: misaligned_d = access_d & lsu_addr_d[0];
         SZ_WORD: misaligned_d = access_d & (|lsu_addr_d[1:0]);
         default: misaligned_d = 1'b0;  // Bytes always aligned
      endcase
   end

   // Misalign wins over fault, PIC only takes words
   assign fault_d = access_d & ~misaligned_d &
                    (region_d.external | (region_d.in_pic & (lsu_p.size != SZ_WORD)));

   assign legal_load_d = access_d & lsu_p.load & ~misaligned_d & ~fault_d;

   // *******************************************************************
   // Read strobes, issued in d
   // *******************************************************************
   assign dccm_rden    = legal_load_d & region_d.in_dccm;
   assign dccm_rd_addr = lsu_addr_d[DCCM_BITS-1:2];  // Word index
   assign picm_rden    = legal_load_d & region_d.in_pic;
   assign picm_rdaddr  = lsu_addr_d;                 // PIC takes the full address

   // Bundle to m
   assign stage_d.pkt        = lsu_p;
   assign stage_d.addr       = lsu_addr_d;
   assign stage_d.region     = region_d;
   assign stage_d.misaligned = misaligned_d;
   assign stage_d.fault      = fault_d;
   assign stage_d.store_data = exu_lsu_rs2_d;

   // Windows must not overlap
   always_comb begin
      assert final (!(dccm_rden && picm_rden))
         else $error("dccm_rden and picm_rden both high");
   end

endmodule

// File: rtl/lsu_pkg.sv
// LSU shared definitions
package lsu_pkg;

   // *******************************************************************
   // Width types
   // *******************************************************************
   typedef logic [31:0]        lsu_addr_t;    // Byte address
   typedef logic [31:0]        lsu_word_t;    // Data word
   typedef logic signed [11:0] lsu_offset_t;  // Immediate offset from decode
   typedef logic [3:0]         lsu_byteen_t;  // One enable per byte lane

   // Memory map
   localparam lsu_addr_t DCCM_BASE = 32'hf004_0000;
   localparam lsu_addr_t DCCM_SIZE = 32'h0001_0000;  // 64 KB
   localparam lsu_addr_t PIC_BASE  = 32'hf00c_0000;
   localparam lsu_addr_t PIC_SIZE  = 32'h0000_8000;  // 32 KB

   localparam int DCCM_BITS      = 16;  // Byte address inside DCCM
   localparam int DCCM_WORD_BITS = 14;  // Word index inside DCCM

   typedef logic [DCCM_WORD_BITS-1:0] dccm_addr_t;

   // Access size, as encoded by decode
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } lsu_size_e;

   // *******************************************************************
   // Packets
   // *******************************************************************
   typedef struct packed {
      logic      valid;   // Instruction is an LSU op
      logic      load;
      logic      store;
      lsu_size_e size;
      logic      unsign;  // Zero extend load data
   } lsu_pkt_t;

   typedef struct packed {
      logic in_dccm;
      logic in_pic;
      logic external;  // Neither window, faults here
   } lsu_region_t;

   // Everything that moves from d to m
   typedef struct packed {
      lsu_pkt_t    pkt;
      lsu_addr_t   addr;        // Effective address
      lsu_region_t region;
      logic        misaligned;
      logic        fault;       // Access fault, misalign excluded
      lsu_word_t   store_data;  // Unshifted rs2
   } lsu_stage_t;

   typedef struct packed {
      logic      exc_valid;
      logic      is_store;      // Store/AMO vs load exception cause
      logic      misaligned;
      logic      access_fault;
      lsu_addr_t addr;          // Goes to mtval
   } lsu_error_pkt_t;

endpackage
